// ==== Bender.yml ====
package:
  name: clio

sources:
  - src/clio_pkg.sv
  - src/clio_reg_if.sv
  - src/clio_bus_port.sv
  - src/clio_beam_counter.sv
  - src/clio_irq_ctrl.sv
  - src/clio_misc_regs.sv
  - src/clio.sv
  - target: test
    files:
      - bench/clio_tb.sv

// ==== bench/clio_tb.sv ====
// clio testbench with clock, reset, lcg, bus tasks, protocol and value assertions, error summary
module clio_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import clio_pkg::*;

	localparam int CYCLE_LIMIT = 20000;	// two frame lines plus register tests
	localparam int LINE_CYCLES = 1591;	// HCNT_MAX + 1
	localparam int NUM_PLAIN = 10;
	localparam int NUM_BP_READS = 16;	// reads under back-pressure

	logic clk_25m;
	logic reset_n;
	logic req_valid;
	logic req_ready;
	logic req_write;
	reg_addr_t req_addr;
	reg_word_t req_wdata;
	logic rsp_valid;
	logic rsp_ready;
	reg_word_t rsp_rdata;
	logic firq_n;

	int errors = 0;
	int cycles = 0;
	int rd_accepted = 0;	// reads taken by the dut
	int rsp_seen = 0;	// responses handed back
	int acc_cycle;	// cycle count just before the last accept edge
	logic stall_on;
	logic [31:0] data_state;
	logic [31:0] stall_state;
	reg_word_t rsp_q[$];
	reg_word_t exp_q[$];
	reg_addr_t plain_addr [NUM_PLAIN] = '{ADDR_CSYSBITS, ADDR_AUDIN, ADDR_AUDOUT, ADDR_CSTATBITS,
			ADDR_WDOG, ADDR_SEED, ADDR_BADBITS, ADDR_SPARE, ADDR_HDELAY, ADDR_ADBCTL};
	reg_word_t plain_val [NUM_PLAIN];	// last value written per plain reg

	clio u_clio (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;	// full period mod 2^32
	endfunction

	function automatic reg_word_t rand_word();
		data_state = lcg_next(data_state);
		return data_state;
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("CHECK FAILED at %0d ns: %s", $time, msg);
	endtask

	task automatic check_eq(input string what, input reg_word_t got, input reg_word_t exp);
		assert (got === exp)
			else report_error($sformatf("%s: got %h, expected %h", what, got, exp));
	endtask

	// holds the request until an edge with req_ready high
	task automatic send_req(input logic wr, input reg_addr_t addr, input reg_word_t data);
		logic taken;
		@(posedge clk_25m);
		req_valid <= 1'b1;
		req_write <= wr;
		req_addr <= addr;
		req_wdata <= data;
		taken = 1'b0;
		while (!taken) begin
			@(negedge clk_25m);
			taken = req_ready;	// settled mid cycle
			acc_cycle = cycles;
			@(posedge clk_25m);
		end
		req_valid <= 1'b0;
	endtask

	task automatic write_word(input reg_addr_t addr, input reg_word_t data);
		send_req(1'b1, addr, data);
	endtask

	task automatic read_word(input reg_addr_t addr, output reg_word_t data);
		send_req(1'b0, addr, '0);
		while (rsp_q.size() == 0) @(negedge clk_25m);
		data = rsp_q.pop_front();
	endtask

	task automatic read_check(input reg_addr_t addr, input reg_word_t exp, input string what);
		reg_word_t got;
		read_word(addr, got);
		check_eq(what, got, exp);
	endtask

	task automatic check_firq(input logic exp, input string what);
		@(negedge clk_25m);	// firq_n is combinational from the regs
		check_eq(what, {31'b0, firq_n}, {31'b0, exp});
	endtask

	// a held response must not move, and no request may slip in behind it
	a_rsp_hold: assert property (@(posedge clk_25m) disable iff (!reset_n)
			(rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata)))
		else report_error("response valid or data changed while held off");
	a_req_stall: assert property (@(posedge clk_25m) disable iff (!reset_n)
			(rsp_valid && !rsp_ready) |-> !req_ready)
		else report_error("req_ready high while a response waits");

	initial begin
		clk_25m = 1'b0;
		forever #20 clk_25m = ~clk_25m;	// 40 ns period
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_25m);
			cycles++;
		end
		$display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	// rsp_ready with random stalls only while stall_on
	initial begin
		forever begin
			@(posedge clk_25m);
			stall_state = lcg_next(stall_state);
			rsp_ready <= stall_on ? stall_state[29] : 1'b1;
		end
	end

	// count accepted reads and delivered responses mid cycle
	initial begin
		forever begin
			@(negedge clk_25m);
			if (reset_n && req_valid && req_ready && !req_write) rd_accepted++;
			if (reset_n && rsp_valid && rsp_ready) begin
				rsp_q.push_back(rsp_rdata);
				rsp_seen++;
			end
		end
	end

	initial begin
		reg_word_t rd;
		reg_word_t rd2;
		reg_word_t d;
		reg_word_t mode_m;
		reg_word_t expctl_m;
		int c0;
		int idx;
		reset_n = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		rsp_ready = 1'b1;
		stall_on = 1'b0;
		data_state = 32'h34b36ea5;
		stall_state = 32'h34b36ea5;
		repeat (3) @(posedge clk_25m);
		reset_n <= 1'b1;

		@(negedge clk_25m);
		check_eq("firq_n after reset", {31'b0, firq_n}, 32'd1);
		check_eq("rsp_valid after reset", {31'b0, rsp_valid}, 32'd0);
		check_eq("req_ready after reset", {31'b0, req_ready}, 32'd1);
		read_check(ADDR_REVISION, REVISION_ID, "revision");
		write_word(ADDR_REVISION, rand_word());
		read_check(ADDR_REVISION, REVISION_ID, "revision after write");
		read_check(ADDR_CSTATBITS, CSTAT_RESET, "cstatbits reset");
		read_check(ADDR_EXPCTL_SET, EXPCTL_RESET, "expctl reset");
		read_check(reg_addr_t'(16'h0300 >> 2), BAD_ACCESS, "unmapped 0x300");
		read_check(ADDR_IRQ0_SET, 32'h3, "irq0 pending after line 0");	// both vints reset to 0

		for (int i = 0; i < NUM_PLAIN; i++) begin
			plain_val[i] = rand_word();
			write_word(plain_addr[i], plain_val[i]);
		end
		for (int i = 0; i < NUM_PLAIN; i++) begin
			read_check(plain_addr[i], plain_val[i], $sformatf("plain reg %h", plain_addr[i]));
		end
		d = rand_word();
		write_word(ADDR_SLACK, d);
		read_check(ADDR_SLACK, d & 32'h0000_03ff, "slack low 10 bits");
		mode_m = '0;
		expctl_m = EXPCTL_RESET;
		for (int i = 0; i < 8; i++) begin
			d = rand_word();
			write_word(d[31] ? ADDR_MODE_SET : ADDR_MODE_CLR, d);	// top bit picks set or clear
			mode_m = d[31] ? (mode_m | d) : (mode_m & ~d);
			d = rand_word();
			write_word(d[31] ? ADDR_EXPCTL_SET : ADDR_EXPCTL_CLR, d);
			expctl_m = d[31] ? (expctl_m | d) : (expctl_m & ~d);
			read_check(i[0] ? ADDR_MODE_CLR : ADDR_MODE_SET, mode_m, "mode set/clear");
			read_check(i[0] ? ADDR_EXPCTL_SET : ADDR_EXPCTL_CLR, expctl_m, "expctl set/clear");
		end

		write_word(ADDR_IRQ0_SET, 32'h20);	// bit 5, enable still clear
		check_firq(1'b1, "irq0 pending without enable");
		write_word(ADDR_IRQ0_EN_SET, 32'h20);
		check_firq(1'b0, "irq0 pending and enabled");
		write_word(ADDR_IRQ0_CLR, 32'h20);
		check_firq(1'b1, "irq0 pending cleared");
		write_word(ADDR_IRQ1_SET, 32'h8);
		check_firq(1'b1, "irq1 pending, nothing enabled");
		write_word(ADDR_IRQ0_EN_SET, 32'h8000_0000);
		check_firq(1'b0, "irq1 pending through irq0 bit 31");
		read_check(ADDR_IRQ0_CLR, 32'h3, "irq0 bit 31 reads as stored");
		write_word(ADDR_IRQ1_CLR, 32'h8);
		check_firq(1'b1, "irq1 pending cleared");
		write_word(ADDR_IRQ0_EN_CLR, 32'h8000_0000);	// irq1 only through its own enable now
		write_word(ADDR_IRQ1_EN_SET, 32'h8);
		write_word(ADDR_IRQ1_SET, 32'h8);
		check_firq(1'b0, "irq1 pending and enabled");
		write_word(ADDR_IRQ1_CLR, 32'h8);
		check_firq(1'b1, "irq1 pending cleared with enable1 set");

		write_word(ADDR_VINT0, 32'd5);
		write_word(ADDR_VINT1, 32'd200);	// line never reached here
		write_word(ADDR_IRQ0_CLR, 32'h3);
		write_word(ADDR_HCNT, reg_word_t'(HCNT_MAX) - 32'd20);
		write_word(ADDR_VCNT, 32'd4);
		c0 = acc_cycle;
		rd = '0;
		while (!rd[0] && (cycles - c0 < 2 * LINE_CYCLES)) read_word(ADDR_IRQ0_SET, rd);
		check_eq("vint0 pending within two lines", {31'b0, rd[0]}, 32'd1);
		check_eq("vint1 pending stays clear", {31'b0, rd[1]}, 32'd0);

		read_word(ADDR_HCNT, rd);
		c0 = acc_cycle;
		repeat (300) @(posedge clk_25m);	// idle gap
		read_word(ADDR_HCNT, rd2);
		check_eq("hcnt distance", rd2, (rd + reg_word_t'(acc_cycle - c0)) % LINE_CYCLES);
		read_word(ADDR_VCNT, rd);
		write_word(ADDR_HCNT, reg_word_t'(HCNT_MAX) - 32'd10);
		write_word(ADDR_VCNT, reg_word_t'(VCNT_MAX));
		repeat (40) @(posedge clk_25m);	// wrap lands well inside this
		read_word(ADDR_VCNT, rd2);
		check_eq("vcnt after frame wrap", rd2 & 32'h0000_07ff, 32'd0);
		check_eq("field bit toggled", {31'b0, rd2[FIELD_BIT]}, {31'b0, ~rd[FIELD_BIT]});

		stall_on = 1'b1;
		for (int i = 0; i < NUM_BP_READS; i++) begin
			idx = int'(rand_word() % NUM_PLAIN);
			exp_q.push_back(plain_val[idx]);
			send_req(1'b0, plain_addr[idx], '0);	// no wait for the response
		end
		while (rsp_q.size() < NUM_BP_READS) @(negedge clk_25m);
		for (int i = 0; i < NUM_BP_READS; i++) begin
			check_eq("response in order", rsp_q.pop_front(), exp_q.pop_front());
		end
		stall_on = 1'b0;
		repeat (4) @(negedge clk_25m);
		check_eq("one response per read", reg_word_t'(rsp_seen), reg_word_t'(rd_accepted));

		$display("run complete: %0d reads, %0d errors", rd_accepted, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
src/clio_pkg.sv
src/clio_reg_if.sv
src/clio_bus_port.sv
src/clio_beam_counter.sv
src/clio_irq_ctrl.sv
src/clio_misc_regs.sv
src/clio.sv
bench/clio_tb.sv

// ==== src/clio.sv ====
// clio register block top level, bus port plus beam, irq and misc register peers
module clio (
	input logic clk_25m,
	input logic reset_n,
	input logic req_valid,
	output logic req_ready,
	input logic req_write,
	input clio_pkg::reg_addr_t req_addr,
	input clio_pkg::reg_word_t req_wdata,
	output logic rsp_valid,
	input logic rsp_ready,
	output clio_pkg::reg_word_t rsp_rdata,
	output logic firq_n
);
	import clio_pkg::*;

	logic line_start;	// hcnt at 0
	beam_count_t vcnt;	// current line, for vint compare

	clio_reg_if u_beam_bus ();
	clio_reg_if u_irq_bus ();
	clio_reg_if u_misc_bus ();

	clio_bus_port u_bus_port (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.req_valid (req_valid),
		.req_write (req_write),
		.req_addr (req_addr),
		.req_wdata (req_wdata),
		.req_ready (req_ready),
		.rsp_valid (rsp_valid),
		.rsp_ready (rsp_ready),
		.rsp_rdata (rsp_rdata),
		.beam_bus (u_beam_bus.host),
		.irq_bus (u_irq_bus.host),
		.misc_bus (u_misc_bus.host)
	);

	clio_beam_counter u_beam (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.bus (u_beam_bus.peer),
		.line_start (line_start),
		.vcnt (vcnt)
	);

	clio_irq_ctrl u_irq (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.bus (u_irq_bus.peer),
		.line_start (line_start),
		.vcnt (vcnt),
		.firq_n (firq_n)
	);

	clio_misc_regs u_misc (
		.clk_25m (clk_25m),
		.reset_n (reset_n),
		.bus (u_misc_bus.peer)
	);

endmodule

// ==== src/clio_beam_counter.sv ====
// horizontal/vertical beam counters, field flag and their cpu registers
module clio_beam_counter (
	input logic clk_25m,
	input logic reset_n,
	clio_reg_if.peer bus,
	output logic line_start,
	output clio_pkg::beam_count_t vcnt
);
	import clio_pkg::*;

	beam_count_t hcnt;	// pixel clock within the line
	logic field;	// odd/even field, flips every frame
	logic wr_hcnt;
	logic wr_vcnt;

	assign wr_hcnt = bus.wr && (bus.addr == ADDR_HCNT);
	assign wr_vcnt = bus.wr && (bus.addr == ADDR_VCNT);
	assign line_start = (hcnt == '0);	// first clock of every line

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			hcnt <= '0;
			vcnt <= '0;
			field <= 1'b1;	// starts on field 1
		end else begin
			if (hcnt == HCNT_MAX) begin
				hcnt <= '0;	// end of line
				if (vcnt == VCNT_MAX) begin
					vcnt <= '0;	// end of field
					field <= ~field;
				end else begin
					vcnt <= vcnt + 1'b1;
				end
			end else begin
				hcnt <= hcnt + 1'b1;
			end
			// cpu writes win over the count
			if (wr_hcnt) begin
				hcnt <= beam_count_t'(bus.wdata);
			end
			if (wr_vcnt) begin
				vcnt <= beam_count_t'(bus.wdata);
			end
		end
	end

	always_comb begin
		bus.hit = 1'b1;
		case (bus.addr)
			ADDR_HCNT: bus.rdata = reg_word_t'(hcnt);
			ADDR_VCNT: bus.rdata = reg_word_t'(vcnt) | (reg_word_t'(field) << FIELD_BIT);
			default: begin
				bus.hit = 1'b0;
				bus.rdata = '0;
			end
		endcase
	end

endmodule

// ==== src/clio_bus_port.sv ====
// request/response handshake, write fan-out to the peers and read data select
module clio_bus_port (
	input logic clk_25m,
	input logic reset_n,
	input logic req_valid,
	input logic req_write,
	input clio_pkg::reg_addr_t req_addr,
	input clio_pkg::reg_word_t req_wdata,
	output logic req_ready,
	output logic rsp_valid,
	input logic rsp_ready,
	output clio_pkg::reg_word_t rsp_rdata,
	clio_reg_if.host beam_bus,
	clio_reg_if.host irq_bus,
	clio_reg_if.host misc_bus
);
	import clio_pkg::*;

	logic req_fire;	// request accepted this clock
	logic rd_fire;	// accepted read
	logic wr_fire;	// accepted write
	reg_word_t rd_sel;	// data of the peer that claims addr

	// only one response may wait, so stall while it is held off
	assign req_ready = !(rsp_valid && !rsp_ready);
	assign req_fire = req_valid && req_ready;
	assign rd_fire = req_fire && !req_write;
	assign wr_fire = req_fire && req_write;

	// same address and data go to every peer
	assign beam_bus.addr = req_addr;
	assign beam_bus.wdata = req_wdata;
	assign beam_bus.wr = wr_fire;
	assign irq_bus.addr = req_addr;
	assign irq_bus.wdata = req_wdata;
	assign irq_bus.wr = wr_fire;
	assign misc_bus.addr = req_addr;
	assign misc_bus.wdata = req_wdata;
	assign misc_bus.wr = wr_fire;

	// peers decode disjoint ranges, so at most one hit
	always_comb begin
		if (beam_bus.hit) begin
			rd_sel = beam_bus.rdata;
		end else if (irq_bus.hit) begin
			rd_sel = irq_bus.rdata;
		end else if (misc_bus.hit) begin
			rd_sel = misc_bus.rdata;
		end else begin
			rd_sel = BAD_ACCESS;	// nobody home
		end
	end

	// response valid flag
	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			rsp_valid <= 1'b0;
		end else if (rd_fire) begin
			rsp_valid <= 1'b1;	// new read replaces the one just taken
		end else if (rsp_ready) begin
			rsp_valid <= 1'b0;	// consumed
		end
	end

	// response data, loaded only on an accepted read
	always_ff @(posedge clk_25m) begin
		if (rd_fire) begin
			rsp_rdata <= rd_sel;	// sampled at the accept edge
		end
	end

endmodule

// ==== src/clio_irq_ctrl.sv ====
// vertical line interrupt registers, irq0/irq1 pending and enable, firq_n
module clio_irq_ctrl (
	input logic clk_25m,
	input logic reset_n,
	clio_reg_if.peer bus,
	input logic line_start,
	input clio_pkg::beam_count_t vcnt,
	output logic firq_n
);
	import clio_pkg::*;

	reg_word_t vint0;	// line for irq0 bit 0
	reg_word_t vint1;	// line for irq0 bit 1
	irq_vec_t pend0;
	irq_vec_t en0;
	irq_vec_t pend1;
	irq_vec_t en1;
	irq_vec_t pend0_nxt;
	logic vint0_hit;
	logic vint1_hit;
	logic any_irq1;	// shows up as irq0 bit 31
	logic irq0_trig;
	logic irq1_trig;

	// only the low 11 bits of vint take part in the compare
	assign vint0_hit = line_start && (vcnt == beam_count_t'(vint0));
	assign vint1_hit = line_start && (vcnt == beam_count_t'(vint1));

	// cpu set/clear first, vint sets ored on top
	always_comb begin
		pend0_nxt = set_clr(pend0, bus.wdata, bus.wr && (bus.addr == ADDR_IRQ0_SET),
				bus.wr && (bus.addr == ADDR_IRQ0_CLR));
		pend0_nxt[0] = pend0_nxt[0] | vint0_hit;
		pend0_nxt[1] = pend0_nxt[1] | vint1_hit;
	end

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			vint0 <= '0;
			vint1 <= '0;
			pend0 <= '0;
			en0 <= '0;
			pend1 <= '0;
			en1 <= '0;
		end else begin
			pend0 <= pend0_nxt;
			en0 <= set_clr(en0, bus.wdata, bus.wr && (bus.addr == ADDR_IRQ0_EN_SET),
					bus.wr && (bus.addr == ADDR_IRQ0_EN_CLR));
			pend1 <= set_clr(pend1, bus.wdata, bus.wr && (bus.addr == ADDR_IRQ1_SET),
					bus.wr && (bus.addr == ADDR_IRQ1_CLR));
			en1 <= set_clr(en1, bus.wdata, bus.wr && (bus.addr == ADDR_IRQ1_EN_SET),
					bus.wr && (bus.addr == ADDR_IRQ1_EN_CLR));
			if (bus.wr && (bus.addr == ADDR_VINT0)) begin
				vint0 <= bus.wdata;
			end
			if (bus.wr && (bus.addr == ADDR_VINT1)) begin
				vint1 <= bus.wdata;
			end
		end
	end

	assign any_irq1 = |pend1;
	assign irq0_trig = |({any_irq1, pend0[30:0]} & en0);	// en0[31] masks the irq1 summary
	assign irq1_trig = |(pend1 & en1);
	assign firq_n = !(irq0_trig || irq1_trig);	// active low to the arm

	// set and clear addresses both read back the vector
	always_comb begin
		bus.hit = 1'b1;
		case (bus.addr)
			ADDR_VINT0: bus.rdata = vint0;
			ADDR_VINT1: bus.rdata = vint1;
			ADDR_IRQ0_SET, ADDR_IRQ0_CLR: bus.rdata = pend0;	// bit 31 as stored
			ADDR_IRQ0_EN_SET, ADDR_IRQ0_EN_CLR: bus.rdata = en0;
			ADDR_IRQ1_SET, ADDR_IRQ1_CLR: bus.rdata = pend1;
			ADDR_IRQ1_EN_SET, ADDR_IRQ1_EN_CLR: bus.rdata = en1;
			default: begin
				bus.hit = 1'b0;
				bus.rdata = '0;
			end
		endcase
	end

endmodule

// ==== src/clio_misc_regs.sv ====
// revision, cstatbits, mode and expctl set/clear, plain storage registers
module clio_misc_regs (
	input logic clk_25m,
	input logic reset_n,
	clio_reg_if.peer bus
);
	import clio_pkg::*;

	reg_word_t csysbits;
	reg_word_t audin;
	reg_word_t audout;
	reg_word_t cstatbits;	// bit 0 is power-on
	reg_word_t wdog;
	reg_word_t seed;
	reg_word_t mode;
	reg_word_t badbits;
	reg_word_t spare;
	reg_word_t hdelay;
	reg_word_t adbctl;
	reg_word_t expctl;	// expansion bus direction
	logic [9:0] slack;	// only 10 bits implemented

	always_ff @(posedge clk_25m or negedge reset_n) begin
		if (!reset_n) begin
			csysbits <= '0;
			audin <= '0;
			audout <= '0;
			cstatbits <= CSTAT_RESET;
			wdog <= '0;
			seed <= '0;
			mode <= '0;
			badbits <= '0;
			spare <= '0;
			hdelay <= '0;
			adbctl <= '0;
			expctl <= EXPCTL_RESET;
			slack <= '0;
		end else begin
			mode <= set_clr(mode, bus.wdata, bus.wr && (bus.addr == ADDR_MODE_SET),
					bus.wr && (bus.addr == ADDR_MODE_CLR));
			expctl <= set_clr(expctl, bus.wdata, bus.wr && (bus.addr == ADDR_EXPCTL_SET),
					bus.wr && (bus.addr == ADDR_EXPCTL_CLR));
			if (bus.wr) begin
				case (bus.addr)	// revision write falls to default
					ADDR_CSYSBITS: csysbits <= bus.wdata;
					ADDR_AUDIN: audin <= bus.wdata;
					ADDR_AUDOUT: audout <= bus.wdata;
					ADDR_CSTATBITS: cstatbits <= bus.wdata;	// whole word, por bit too
					ADDR_WDOG: wdog <= bus.wdata;
					ADDR_SEED: seed <= bus.wdata;
					ADDR_BADBITS: badbits <= bus.wdata;
					ADDR_SPARE: spare <= bus.wdata;
					ADDR_HDELAY: hdelay <= bus.wdata;
					ADDR_ADBCTL: adbctl <= bus.wdata;
					ADDR_SLACK: slack <= bus.wdata[9:0];
					default: ;
				endcase
			end
		end
	end

	always_comb begin
		bus.hit = 1'b1;
		case (bus.addr)
			ADDR_REVISION: bus.rdata = REVISION_ID;	// fixed
			ADDR_CSYSBITS: bus.rdata = csysbits;
			ADDR_AUDIN: bus.rdata = audin;
			ADDR_AUDOUT: bus.rdata = audout;
			ADDR_CSTATBITS: bus.rdata = cstatbits;
			ADDR_WDOG: bus.rdata = wdog;
			ADDR_SEED: bus.rdata = seed;
			ADDR_MODE_SET, ADDR_MODE_CLR: bus.rdata = mode;
			ADDR_BADBITS: bus.rdata = badbits;
			ADDR_SPARE: bus.rdata = spare;
			ADDR_HDELAY: bus.rdata = hdelay;
			ADDR_ADBCTL: bus.rdata = adbctl;
			ADDR_SLACK: bus.rdata = reg_word_t'(slack);	// upper bits read 0
			ADDR_EXPCTL_SET, ADDR_EXPCTL_CLR: bus.rdata = expctl;
			default: begin
				bus.hit = 1'b0;
				bus.rdata = '0;
			end
		endcase
	end

endmodule

// ==== src/clio_pkg.sv ====
// clio register block types, register map, beam limits, reset values, set/clear helper
package clio_pkg;

	typedef logic [31:0] reg_word_t;	// cpu data word
	typedef logic [13:0] reg_addr_t;	// word address = byte addr 15:2
	typedef logic [10:0] beam_count_t;	// h or v beam position
	typedef logic [31:0] irq_vec_t;	// pending / enable vector

	localparam beam_count_t HCNT_MAX = 11'd1590;	// last pixel clock of a line
	localparam beam_count_t VCNT_MAX = 11'd262;	// last line of a field
	localparam int FIELD_BIT = 11;	// field flag position in vcnt reads

	localparam reg_word_t REVISION_ID = 32'h0202_2000;	// chip rev in top byte
	localparam reg_word_t EXPCTL_RESET = 32'h0000_0080;	// arm owns the expansion bus
	localparam reg_word_t CSTAT_RESET = 32'h0000_0001;	// power-on flag
	localparam reg_word_t BAD_ACCESS = 32'hBADA_CCE5;	// unmapped read value

	// word addresses, written as byte offset >> 2
	localparam reg_addr_t ADDR_REVISION = reg_addr_t'(16'h0000 >> 2);
	localparam reg_addr_t ADDR_CSYSBITS = reg_addr_t'(16'h0004 >> 2);
	localparam reg_addr_t ADDR_VINT0 = reg_addr_t'(16'h0008 >> 2);
	localparam reg_addr_t ADDR_VINT1 = reg_addr_t'(16'h000C >> 2);
	localparam reg_addr_t ADDR_AUDIN = reg_addr_t'(16'h0020 >> 2);
	localparam reg_addr_t ADDR_AUDOUT = reg_addr_t'(16'h0024 >> 2);
	localparam reg_addr_t ADDR_CSTATBITS = reg_addr_t'(16'h0028 >> 2);
	localparam reg_addr_t ADDR_WDOG = reg_addr_t'(16'h002C >> 2);
	localparam reg_addr_t ADDR_HCNT = reg_addr_t'(16'h0030 >> 2);
	localparam reg_addr_t ADDR_VCNT = reg_addr_t'(16'h0034 >> 2);
	localparam reg_addr_t ADDR_SEED = reg_addr_t'(16'h0038 >> 2);
	localparam reg_addr_t ADDR_IRQ0_SET = reg_addr_t'(16'h0040 >> 2);
	localparam reg_addr_t ADDR_IRQ0_CLR = reg_addr_t'(16'h0044 >> 2);
	localparam reg_addr_t ADDR_IRQ0_EN_SET = reg_addr_t'(16'h0048 >> 2);
	localparam reg_addr_t ADDR_IRQ0_EN_CLR = reg_addr_t'(16'h004C >> 2);
	localparam reg_addr_t ADDR_MODE_SET = reg_addr_t'(16'h0050 >> 2);
	localparam reg_addr_t ADDR_MODE_CLR = reg_addr_t'(16'h0054 >> 2);
	localparam reg_addr_t ADDR_BADBITS = reg_addr_t'(16'h0058 >> 2);
	localparam reg_addr_t ADDR_SPARE = reg_addr_t'(16'h005C >> 2);
	localparam reg_addr_t ADDR_IRQ1_SET = reg_addr_t'(16'h0060 >> 2);
	localparam reg_addr_t ADDR_IRQ1_CLR = reg_addr_t'(16'h0064 >> 2);
	localparam reg_addr_t ADDR_IRQ1_EN_SET = reg_addr_t'(16'h0068 >> 2);
	localparam reg_addr_t ADDR_IRQ1_EN_CLR = reg_addr_t'(16'h006C >> 2);
	localparam reg_addr_t ADDR_HDELAY = reg_addr_t'(16'h0080 >> 2);
	localparam reg_addr_t ADDR_ADBCTL = reg_addr_t'(16'h0088 >> 2);
	localparam reg_addr_t ADDR_SLACK = reg_addr_t'(16'h0220 >> 2);
	localparam reg_addr_t ADDR_EXPCTL_SET = reg_addr_t'(16'h0400 >> 2);
	localparam reg_addr_t ADDR_EXPCTL_CLR = reg_addr_t'(16'h0404 >> 2);

	// set address ORs data in, clear address knocks data bits out
	function automatic reg_word_t set_clr(input reg_word_t cur, input reg_word_t data,
			input logic set_wr, input logic clr_wr);
		reg_word_t set_mask;
		reg_word_t clr_mask;
		set_mask = set_wr ? data : '0;	// nothing ored when idle
		clr_mask = clr_wr ? data : '0;	// nothing cleared when idle
		return (cur | set_mask) & ~clr_mask;
	endfunction

endpackage

// ==== src/clio_reg_if.sv ====
// register access interface between the bus port and one register peer
interface clio_reg_if;
	import clio_pkg::*;

	logic wr;	// write strobe, one clock
	reg_addr_t addr;	// broadcast word address
	reg_word_t wdata;	// broadcast write data
	reg_word_t rdata;	// peer read value, zero when not hit
	logic hit;	// addr belongs to this peer

	modport host (
		output wr,
		output addr,
		output wdata,
		input rdata,
		input hit
	);

	modport peer (
		input wr,
		input addr,
		input wdata,
		output rdata,
		output hit
	);

endinterface
